/* design/ac_cfg_pkg.sv */
// numeric defaults and fixed result widths shared by the period detector and its testbench
package ac_cfg_pkg;

    // default sample format, signed two's complement
    parameter int DEF_DATA_WIDTH = 12;

    // samples gathered per analysis window
    parameter int DEF_WINDOW_LEN = 64;

    // highest lag searched, must stay below the window length
    parameter int DEF_MAX_LAG    = 32;

    // signed correlation sum width
    // 12b x 12b products summed over 64 samples need 30 bits, extra headroom
    // covers wider samples or longer windows
    parameter int ACC_WIDTH      = 40;

    // width of lag and period values on the result path
    parameter int PERIOD_WIDTH   = 16;

endpackage

/* design/ac_ctrl_pkg.sv */
// control encodings of the correlation engine, referenced by scoped name inside the design
package ac_ctrl_pkg;

    // engine sequencing
    //   IDLE      wait for the first strobe with en high
    //   COLLECT   fill the window buffer
    //   CORRELATE one product per cycle for the current lag
    //   EMIT      present r(k) on the result stream
    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        CORRELATE,
        EMIT
    } engine_state_t;

endpackage

/* design/lag_result_if.sv */
// per-lag correlation result stream, driven by the engine and consumed by the peak picker
`timescale 1ns/1ns

interface lag_result_if;

    logic                                   valid;  // one-cycle strobe, no ready
    logic        [ac_cfg_pkg::PERIOD_WIDTH-1:0] lag;    // 1 .. MAX_LAG, increasing
    logic signed [ac_cfg_pkg::ACC_WIDTH-1:0]    value;  // r(lag)
    logic                                   last;   // set with the MAX_LAG strobe

    modport source (output valid, output lag, output value, output last);

    modport sink (input valid, input lag, input value, input last);

endinterface

/* design/adc_sample_sync.sv */
// moves ADC samples from the adc_clk domain into clk as a one-cycle strobe plus held word
`timescale 1ns/1ns

module adc_sample_sync #(
    parameter int DATA_WIDTH = 12
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         adc_clk,
    input  logic signed [DATA_WIDTH-1:0] data_in,
    output logic                         sample_valid,
    output logic signed [DATA_WIDTH-1:0] sample
);

    logic signed [DATA_WIDTH-1:0] cap_q;  // adc domain holding register
    logic                         adc_s1;
    logic                         adc_s2;
    logic                         adc_s3; // previous level, for edge detect
    logic                         adc_rise;

    // ADC updates data on its rising edge, so take it half a period later
    always_ff @(negedge adc_clk) begin
        cap_q <= data_in;
    end

    // two-flop synchronizer on the sampling clock itself
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            adc_s1 <= 1'b0;
            adc_s2 <= 1'b0;
            adc_s3 <= 1'b0;
        end else begin
            adc_s1 <= adc_clk;
            adc_s2 <= adc_s1;
            adc_s3 <= adc_s2;
        end
    end

    assign adc_rise = adc_s2 & ~adc_s3;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= adc_rise;
        end
    end

    // cap_q has been quiet since the last falling edge, safe to sample here
    always_ff @(posedge clk) begin
        if (adc_rise) begin
            sample <= cap_q;
        end
    end

endmodule

/* design/autocorr_engine.sv */
// collects one window of samples and computes r(k) for lags 1..MAX_LAG with a single MAC
`timescale 1ns/1ns

module autocorr_engine #(
    parameter int DATA_WIDTH = 12,
    parameter int WINDOW_LEN = 64,
    parameter int MAX_LAG    = 32
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         en,
    input  logic                         sample_valid,
    input  logic signed [DATA_WIDTH-1:0] sample,
    lag_result_if.source                 res
);

    localparam int IDX_W = (WINDOW_LEN > 2) ? $clog2(WINDOW_LEN) : 1;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WINDOW_LEN - 1);
    localparam logic [IDX_W-1:0] LAST_LAG = IDX_W'(MAX_LAG);

    ac_ctrl_pkg::engine_state_t state;

    logic signed [DATA_WIDTH-1:0] mem [WINDOW_LEN];  // window buffer

    logic [IDX_W-1:0] wr_idx;   // next write slot, 0 whenever idle
    logic [IDX_W-1:0] rd_idx;   // n
    logic [IDX_W-1:0] lag_cnt;  // k, fits since MAX_LAG < WINDOW_LEN
    logic [IDX_W-1:0] pair_idx; // n + k
    logic             wr_en;
    logic             pair_last;

    logic signed [2*DATA_WIDTH-1:0]         prod;
    logic signed [ac_cfg_pkg::ACC_WIDTH-1:0] acc;

    // a window starts only from idle with en high, then runs regardless of en
    assign wr_en = sample_valid &&
                   ((state == ac_ctrl_pkg::IDLE && en) || state == ac_ctrl_pkg::COLLECT);

    assign pair_idx  = rd_idx + lag_cnt;
    assign pair_last = (pair_idx == LAST_IDX);  // final product of this lag

    assign prod = mem[rd_idx] * mem[pair_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ac_ctrl_pkg::IDLE;
            wr_idx  <= '0;
            rd_idx  <= '0;
            lag_cnt <= IDX_W'(1);
        end else begin
            if (wr_en) begin
                wr_idx <= (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
            end

            case (state)
                ac_ctrl_pkg::IDLE: begin
                    if (wr_en) begin
                        state <= ac_ctrl_pkg::COLLECT;
                    end
                end

                ac_ctrl_pkg::COLLECT: begin
                    if (wr_en && wr_idx == LAST_IDX) begin
                        state  <= ac_ctrl_pkg::CORRELATE;
                        rd_idx <= '0;
                    end
                end

                ac_ctrl_pkg::CORRELATE: begin
                    if (pair_last) begin
                        state  <= ac_ctrl_pkg::EMIT;
                        rd_idx <= '0;
                    end else begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                end

                ac_ctrl_pkg::EMIT: begin
                    if (lag_cnt == LAST_LAG) begin
                        state   <= ac_ctrl_pkg::IDLE;  // strobes in CORRELATE were dropped
                        lag_cnt <= IDX_W'(1);
                    end else begin
                        state   <= ac_ctrl_pkg::CORRELATE;
                        lag_cnt <= lag_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= ac_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= sample;
        end
    end

    // sum of x[n]*x[n+k], zeroed outside of CORRELATE
    always_ff @(posedge clk) begin
        if (state == ac_ctrl_pkg::CORRELATE) begin
            acc <= acc + ac_cfg_pkg::ACC_WIDTH'(prod);
        end else begin
            acc <= '0;
        end
    end

    // result is on the stream for the single EMIT cycle
    assign res.valid = (state == ac_ctrl_pkg::EMIT);
    assign res.lag   = ac_cfg_pkg::PERIOD_WIDTH'(lag_cnt);
    assign res.value = acc;
    assign res.last  = (lag_cnt == LAST_LAG);

endmodule

/* design/peak_picker.sv */
// finds the strongest lag of each window and reports it as the period with a stability flag
`timescale 1ns/1ns

module peak_picker (
    input  logic                                 clk,
    input  logic                                 arst_n,
    lag_result_if.sink                           res,
    output logic                                 done,
    output logic [ac_cfg_pkg::PERIOD_WIDTH-1:0]  period,
    output logic                                 stable
);

    localparam int AW = ac_cfg_pkg::ACC_WIDTH;

    localparam logic signed [AW-1:0] MOST_NEG = {1'b1, {(AW - 1){1'b0}}};

    logic signed [AW-1:0]                   max_val;
    logic signed [AW-1:0]                   sec_val;
    logic        [ac_cfg_pkg::PERIOD_WIDTH-1:0] max_lag;

    logic signed [AW-1:0]                   nxt_max;
    logic signed [AW-1:0]                   nxt_sec;
    logic        [ac_cfg_pkg::PERIOD_WIDTH-1:0] nxt_lag;

    // tracking including the current result, strict compare keeps the lower lag
    always_comb begin
        nxt_max = max_val;
        nxt_sec = sec_val;
        nxt_lag = max_lag;
        if (res.value > max_val) begin
            nxt_sec = max_val;
            nxt_max = res.value;
            nxt_lag = res.lag;
        end else if (res.value > sec_val) begin
            nxt_sec = res.value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            max_val <= MOST_NEG;
            sec_val <= MOST_NEG;
            max_lag <= '0;
            done    <= 1'b0;
            period  <= '0;
            stable  <= 1'b0;
        end else begin
            done <= res.valid && res.last;
            if (res.valid) begin
                if (res.last) begin
                    period  <= nxt_lag;
                    stable  <= (nxt_sec > (nxt_max >>> 1));  // runner-up within half of peak
                    max_val <= MOST_NEG;  // fresh start for next window
                    sec_val <= MOST_NEG;
                    max_lag <= '0;
                end else begin
                    max_val <= nxt_max;
                    sec_val <= nxt_sec;
                    max_lag <= nxt_lag;
                end
            end
        end
    end

endmodule

/* design/period_detect_top.sv */
// period detector top level: ADC capture, autocorrelation engine and peak picker
`timescale 1ns/1ns

module period_detect_top #(
    parameter int DATA_WIDTH = ac_cfg_pkg::DEF_DATA_WIDTH,
    parameter int WINDOW_LEN = ac_cfg_pkg::DEF_WINDOW_LEN,
    parameter int MAX_LAG    = ac_cfg_pkg::DEF_MAX_LAG
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                adc_clk,
    input  logic                                en,
    input  logic signed [DATA_WIDTH-1:0]        data_in,
    output logic                                done,
    output logic [ac_cfg_pkg::PERIOD_WIDTH-1:0] period,
    output logic                                stable
);

    logic                         sample_valid;
    logic signed [DATA_WIDTH-1:0] sample;

    lag_result_if res_if ();  // engine to peak picker

    adc_sample_sync #(
        .DATA_WIDTH (DATA_WIDTH)
    ) sync0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .adc_clk      (adc_clk),
        .data_in      (data_in),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    autocorr_engine #(
        .DATA_WIDTH (DATA_WIDTH),
        .WINDOW_LEN (WINDOW_LEN),
        .MAX_LAG    (MAX_LAG)
    ) engine0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .en           (en),
        .sample_valid (sample_valid),
        .sample       (sample),
        .res          (res_if.source)
    );

    peak_picker picker0 (
        .clk    (clk),
        .arst_n (arst_n),
        .res    (res_if.sink),
        .done   (done),
        .period (period),
        .stable (stable)
    );

endmodule

/* bench/period_detect_tb.sv */
// self-checking testbench for period_detect_top, compiled with the sources in compile.f
`timescale 1ns/1ns

module period_detect_tb;

    localparam int DATA_W = ac_cfg_pkg::DEF_DATA_WIDTH;
    localparam int WIN    = ac_cfg_pkg::DEF_WINDOW_LEN;
    localparam int LAGS   = ac_cfg_pkg::DEF_MAX_LAG;
    localparam int PW     = ac_cfg_pkg::PERIOD_WIDTH;

    localparam real CLK_NS      = 100.0;
    localparam real ADC_NS      = 10.0 * CLK_NS;  // adc_clk toggles every 5 clk edges
    localparam int  CORR_CYCLES = LAGS * (WIN + 1) - LAGS * (LAGS + 1) / 2;
    localparam int  NUM_WINDOWS = 7;
    localparam real WATCHDOG_NS = 1.5 * NUM_WINDOWS *
                                  ((WIN + 2) * ADC_NS + CORR_CYCLES * CLK_NS);

    // enough adc periods to fill and correlate a whole window
    localparam int  EN_LOW_PERIODS = WIN + 2 + CORR_CYCLES / 10 + 1;

    localparam longint ACC_MIN = -(longint'(1) <<< (ac_cfg_pkg::ACC_WIDTH - 1));

    typedef enum int {SQUARE, SAWTOOTH, RANDOM} wave_t;

    logic                     clk;
    logic                     arst_n;
    logic                     adc_clk;
    logic                     en;
    logic signed [DATA_W-1:0] data_in;
    logic                     done;
    logic        [PW-1:0]     period;
    logic                     stable;

    // one entry per window still waiting for its done
    string         exp_name_q[$];
    logic [PW-1:0] exp_period_q[$];
    logic          exp_stable_q[$];

    int          done_count = 0;
    logic [31:0] rng;

    period_detect_top dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .adc_clk (adc_clk),
        .en      (en),
        .data_in (data_in),
        .done    (done),
        .period  (period),
        .stable  (stable)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected {stable, period} of one window, straight from the r(k) definition
    function automatic logic [PW:0] ref_result(input logic signed [DATA_W-1:0] win[$]);
        longint r;
        longint max_v;
        longint sec_v;
        int     max_k;
        int     k;
        int     n;
        logic   stab;
        max_v = ACC_MIN;
        sec_v = ACC_MIN;
        max_k = 0;
        for (k = 1; k <= LAGS; k++) begin
            r = 0;
            for (n = 0; n <= WIN - 1 - k; n++) begin
                r += longint'(win[n]) * longint'(win[n + k]);
            end
            if (r > max_v) begin  // strict, so a tie keeps the lower lag
                sec_v = max_v;
                max_v = r;
                max_k = k;
            end else if (r > sec_v) begin
                sec_v = r;
            end
        end
        stab = (sec_v > (max_v >>> 1));
        return {stab, PW'(max_k)};
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
        report_fail($sformatf("FAIL %s %s expected %0d actual %0d",
                              test, what, expected, actual));
    endtask

    // one full adc_clk period, data changes with the rising edge
    task automatic adc_period(input logic signed [DATA_W-1:0] value, input logic en_level);
        @(posedge clk);
        adc_clk <= 1'b1;
        data_in <= value;
        repeat (5) @(posedge clk);
        adc_clk <= 1'b0;
        en      <= en_level;  // seen by the strobe of this period's sample
        repeat (4) @(posedge clk);
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (done === 1'b0)
            else report_mismatch(phase, "done", 64'd0, {63'd0, done});
        assert (period === '0)
            else report_mismatch(phase, "period", 64'd0, {48'd0, period});
        assert (stable === 1'b0)
            else report_mismatch(phase, "stable", 64'd0, {63'd0, stable});
    endtask

    // builds one window, queues its expected result, then plays it to the ADC input
    task automatic run_window(input string name, input wave_t wave, input int per);
        logic signed [DATA_W-1:0] win[$];
        logic signed [DATA_W-1:0] v;
        logic        [PW:0]       expected;
        int                       n;
        int                       step;
        step = (per > 1) ? 1800 / (per - 1) : 0;
        for (n = 0; n < WIN; n++) begin
            case (wave)
                SQUARE: begin
                    v = ((n % per) < per / 2) ? 1000 : -1000;
                end
                SAWTOOTH: begin
                    v = (n % per) * step - step * (per - 1) / 2;  // centred ramp
                end
                default: begin
                    rng = xorshift32(rng);
                    v   = rng[DATA_W-1:0];
                end
            endcase
            win.push_back(v);
        end
        expected = ref_result(win);
        exp_name_q.push_back(name);
        exp_period_q.push_back(expected[PW-1:0]);
        exp_stable_q.push_back(expected[PW]);
        for (n = 0; n < WIN; n++) begin
            adc_period(win[n], n == 0);  // en high only around sample 0
        end
    endtask

    // keep the ADC running with ignored data until enough results came back
    task automatic idle_until(input int count);
        while (done_count < count) begin
            rng = xorshift32(rng);
            adc_period(rng[DATA_W-1:0], 1'b0);
        end
    endtask

    initial begin : compare
        string         name;
        logic [PW-1:0] exp_period;
        logic          exp_stable;
        forever begin
            @(posedge clk);
            if (done === 1'b1) begin
                assert (exp_name_q.size() > 0)
                    else report_fail("done pulsed although no window was pending");
                name       = exp_name_q.pop_front();
                exp_period = exp_period_q.pop_front();
                exp_stable = exp_stable_q.pop_front();
                assert (period === exp_period)
                    else report_mismatch(name, "period", {48'd0, exp_period}, {48'd0, period});
                assert (stable === exp_stable)
                    else report_mismatch(name, "stable", {63'd0, exp_stable}, {63'd0, stable});
                done_count++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("no period result arrived in time, the run is stopped");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int i;
        clk     = 1'b0;
        arst_n  = 1'b0;
        adc_clk = 1'b0;
        en      = 1'b0;
        data_in = '0;
        rng     = 32'h40131219;

        // reset state, held for 5 cycles and checked a few cycles past release
        repeat (5) begin
            @(negedge clk);
            check_idle_outputs("reset_during");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("reset_after");
        end

        run_window("square_p8", SQUARE, 8);
        idle_until(1);

        // second window starts right after the first done
        run_window("saw_p13", SAWTOOTH, 13);
        idle_until(2);
        run_window("saw_p5", SAWTOOTH, 5);
        idle_until(3);

        for (i = 0; i < 3; i++) begin
            run_window($sformatf("random_%0d", i), RANDOM, 1);
            idle_until(4 + i);
        end

        // en low long enough that an ignored en would have finished a window
        repeat (EN_LOW_PERIODS) adc_period(DATA_W'(300), 1'b0);
        assert (done_count == 6)
            else report_fail("done pulsed while en was held low");
        run_window("en_late", RANDOM, 1);
        idle_until(7);

        if (exp_name_q.size() == 0 && done_count == NUM_WINDOWS) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_fail("not every window produced its result");
        end
    end

endmodule

/* compile.f */
design/ac_cfg_pkg.sv
design/ac_ctrl_pkg.sv
design/lag_result_if.sv
design/adc_sample_sync.sv
design/autocorr_engine.sv
design/peak_picker.sv
design/period_detect_top.sv
bench/period_detect_tb.sv

/* Bender.yml */
package:
  name: period_detect

sources:
  # packages first, the rest depends on them
  - design/ac_cfg_pkg.sv
  - design/ac_ctrl_pkg.sv
  - design/lag_result_if.sv
  - design/adc_sample_sync.sv
  - design/autocorr_engine.sv
  - design/peak_picker.sv
  - design/period_detect_top.sv

  - target: simulation
    files:
      - bench/period_detect_tb.sv
